// File: Makefile
# Build the testbench with Verilator, run it, and search the log for the result

.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal -f files.f --top-module leaf_tb -Mdir obj_dir
	./obj_dir/Vleaf_tb | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/leaf_tb_lib.svh
`ifndef leaf_tb_lib_svh
`define leaf_tb_lib_svh

// ****************************************
// Reference model
// ****************************************
// Streams 1 to 4 add one to the word, streams 5 and 6 add the word to a total
function automatic word_t kernel_ref(int stream, word_t din, word_t total);
    word_t result;
    if (stream >= 5) begin
        result = total + din;
    end else begin
        result = din + 32'd1;
    end
    return result;
endfunction

// Header of a stream as the last config packet for it set it up
function automatic route_t route_ref(int stream);
    return route_model[stream - 1];
endfunction

function automatic tree_packet_t make_packet(
    logic [leaf_bits-1:0] leaf,
    logic [port_bits-1:0] port,
    logic [addr_bits-1:0] addr,
    word_t                payload
);
    tree_packet_t p;
    p.valid = 1'b1;
    p.dest_leaf = leaf;
    p.dest_port = port;
    p.addr = addr;
    p.payload = payload;
    return p;
endfunction

// ****************************************
// Compare tasks
// ****************************************
task automatic check_packet(string name, tree_packet_t got, tree_packet_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("Fail %s: expected 0x%h, got 0x%h", name, exp, got);
    end
endtask

task automatic check_route(string name, route_t got, route_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("Fail %s: expected 0x%h, got 0x%h", name, exp, got);
    end
endtask

`endif

// File: bench/leaf_tb.sv
`timescale 1ns/1ps

module leaf_tb;
    import leaf_pkg::*;

    localparam int n_pre = 6;
    localparam int n_rand = 200;
    localparam int n_resend = 8;
    localparam int n_late = 40;
    localparam int total_words = 4 * n_pre + n_rand + 4 * n_resend + n_late;
    localparam int watchdog_cycles = total_words * 20 + 2000;
    localparam logic [leaf_bits-1:0] own_leaf = 5'd9;

    logic clk_400;
    logic reset;
    logic ap_start;
    logic resend;
    tree_packet_t din_leaf_bft2interface;
    tree_packet_t dout_leaf_interface2bft;

    int value_errors;
    int event_errors;
    int packets_checked;
    int words_sent;
    logic start_sent;
    route_t route_model [num_out_ports];
    word_t exp_q [num_out_ports][$];
    word_t total_1;
    word_t total_2;

    `include "leaf_tb_lib.svh"

    leaf_i4o6 dut0 (
        .clk_400                 (clk_400),
        .reset                   (reset),
        .ap_start                (ap_start),
        .resend                  (resend),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

    initial begin
        clk_400 = 1'b0;
        forever begin
            #4 clk_400 = ~clk_400;
        end
    end

    // ****************************************
    // Stimulus helpers
    // ****************************************
    // One packet every other cycle keeps the output rate within one per cycle
    task automatic drive_packet(tree_packet_t p);
        @(posedge clk_400);
        #1;
        din_leaf_bft2interface = p;
        @(posedge clk_400);
        #1;
        din_leaf_bft2interface = '0;
    endtask

    task automatic send_word(int port, word_t w);
        exp_q[port - 1].push_back(kernel_ref(port, w, '0));
        if (port == 1) begin
            total_1 = kernel_ref(5, w, total_1);
            exp_q[4].push_back(total_1);
        end
        if (port == 2) begin
            total_2 = kernel_ref(6, w, total_2);
            exp_q[5].push_back(total_2);
        end
        words_sent++;
        drive_packet(make_packet(own_leaf, port_bits'(port), '0, w));
    endtask

    task automatic send_config(int stream, route_t r);
        route_model[stream - 1] = r;
        drive_packet(make_packet(own_leaf, '0, addr_bits'(stream), {23'd0, r}));
    endtask

    task automatic verify_routes();
        for (int j = 0; j < num_out_ports; j++) begin
            check_route($sformatf("routes[%0d]", j), dut0.leaf_interface_inst.routes[j],
                        route_ref(j + 1));
        end
    endtask

    task automatic pulse_start();
        @(posedge clk_400);
        #1;
        ap_start = 1'b1;
        start_sent = 1'b1;
        @(posedge clk_400);
        #1;
        ap_start = 1'b0;
    endtask

    // Returns once every expected word has come out
    task automatic wait_drain();
        int left;
        left = 1;
        while (left != 0) begin
            @(posedge clk_400);
            left = 0;
            for (int j = 0; j < num_out_ports; j++) begin
                left += exp_q[j].size();
            end
        end
        repeat (20) @(posedge clk_400);
    endtask

    task automatic report_leftovers();
        for (int j = 0; j < num_out_ports; j++) begin
            if (exp_q[j].size() != 0) begin
                event_errors++;
                $display("Stream %0d still has %0d words that never came out", j + 1,
                         exp_q[j].size());
            end
        end
    endtask

    task automatic print_counts();
        $display("Value errors %0d, other errors %0d, words sent %0d, packets checked %0d",
                 value_errors, event_errors, words_sent, packets_checked);
    endtask

    // ****************************************
    // Output monitor
    // ****************************************
    always @(posedge clk_400) begin
        tree_packet_t got;
        route_t r;
        int stream;
        got = dout_leaf_interface2bft;
        stream = int'(got.addr);
        if (!reset && got.valid) begin
            if (!start_sent) begin
                event_errors++;
                $display("Output packet on stream %0d came out before ap_start", stream);
            end
            if (resend) begin
                event_errors++;
                $display("Output packet came out while resend was high");
            end
            if (stream < 1 || stream > num_out_ports) begin
                event_errors++;
                $display("Output packet has unknown stream number %0d in addr", stream);
            end else if (exp_q[stream - 1].size() == 0) begin
                event_errors++;
                $display("Output packet on stream %0d with no word expected", stream);
            end else begin
                r = route_ref(stream);
                check_packet($sformatf("dout_leaf_interface2bft stream %0d", stream), got,
                             make_packet(r.leaf, r.port, addr_bits'(stream),
                                         exp_q[stream - 1].pop_front()));
                packets_checked++;
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_400);
        event_errors++;
        $display("Timeout after %0d cycles with words still in flight", watchdog_cycles);
        report_leftovers();
        print_counts();
        $display("tests failed");
        $finish;
    end

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        route_t r;
        void'($urandom(32'h3e9b));
        value_errors = 0;
        event_errors = 0;
        packets_checked = 0;
        words_sent = 0;
        start_sent = 1'b0;
        total_1 = '0;
        total_2 = '0;
        for (int j = 0; j < num_out_ports; j++) begin
            route_model[j] = '0;
        end
        reset = 1'b1;
        ap_start = 1'b0;
        resend = 1'b0;
        din_leaf_bft2interface = '0;
        repeat (4) @(posedge clk_400);
        #1;
        reset = 1'b0;

        for (int s = 1; s <= num_out_ports; s++) begin
            r = route_t'(9'($urandom()));
            send_config(s, r);
        end
        verify_routes();

        // Words wait in the input queues while the kernel is held in reset
        for (int i = 0; i < n_pre; i++) begin
            for (int p = 1; p <= num_in_ports; p++) begin
                send_word(p, $urandom());
            end
        end
        repeat (40) @(posedge clk_400);
        pulse_start();
        wait_drain();

        for (int i = 0; i < n_rand; i++) begin
            send_word($urandom_range(num_in_ports, 1), $urandom());
        end
        wait_drain();

        @(posedge clk_400);
        #1;
        resend = 1'b1;
        for (int i = 0; i < n_resend; i++) begin
            for (int p = 1; p <= num_in_ports; p++) begin
                send_word(p, $urandom());
            end
        end
        repeat (40) @(posedge clk_400);
        #1;
        resend = 1'b0;
        wait_drain();

        // New routes with a different leaf for every stream
        for (int s = 1; s <= num_out_ports; s++) begin
            r.leaf = ~route_model[s - 1].leaf;
            r.port = 4'($urandom());
            send_config(s, r);
        end
        verify_routes();
        for (int i = 0; i < n_late; i++) begin
            send_word($urandom_range(num_in_ports, 1), $urandom());
        end
        wait_drain();

        print_counts();
        if (value_errors == 0 && event_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: design/leaf_i4o6.sv
`timescale 1ns/1ps

module leaf_i4o6 (
    input  logic                   clk_400,
    input  logic                   reset,
    input  logic                   ap_start,
    input  logic                   resend,
    input  leaf_pkg::tree_packet_t din_leaf_bft2interface,
    output leaf_pkg::tree_packet_t dout_leaf_interface2bft
);
    import leaf_pkg::*;

    // Kernel side streams between the interface and the user kernel
    word_t dout_leaf_interface2user [num_in_ports];
    logic [num_in_ports-1:0] vld_interface2user;
    logic [num_in_ports-1:0] ack_user2interface;
    word_t din_leaf_user2interface [num_out_ports];
    logic [num_out_ports-1:0] vld_user2interface;
    logic [num_out_ports-1:0] ack_interface2user;
    logic reset_ap_start_user;

    leaf_interface leaf_interface_inst (
        .clk_400                  (clk_400),
        .reset                    (reset),
        .ap_start                 (ap_start),
        .resend                   (resend),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user),
        .reset_ap_start_user      (reset_ap_start_user)
    );

    user_kernel user_kernel_inst (
        .clk_user                 (clk_400),
        .reset                    (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

endmodule

// File: design/leaf_interface.sv
`timescale 1ns/1ps

module leaf_interface (
    input  logic                                clk_400,
    input  logic                                reset,
    input  logic                                ap_start,
    input  logic                                resend,
    input  leaf_pkg::tree_packet_t              din_leaf_bft2interface,
    output leaf_pkg::tree_packet_t              dout_leaf_interface2bft,
    output leaf_pkg::word_t                     dout_leaf_interface2user [leaf_pkg::num_in_ports],
    output logic [leaf_pkg::num_in_ports-1:0]   vld_interface2user,
    input  logic [leaf_pkg::num_in_ports-1:0]   ack_user2interface,
    input  leaf_pkg::word_t                     din_leaf_user2interface [leaf_pkg::num_out_ports],
    input  logic [leaf_pkg::num_out_ports-1:0]  vld_user2interface,
    output logic [leaf_pkg::num_out_ports-1:0]  ack_interface2user,
    output logic                                reset_ap_start_user
);
    import leaf_pkg::*;

    logic started;
    word_t in_word;
    logic [num_in_ports-1:0] in_push;
    route_t routes [num_out_ports];
    word_t out_word [num_out_ports];
    logic [num_out_ports-1:0] out_vld;
    logic [num_out_ports-1:0] out_pop;

    // Kernel is held in reset until the first ap_start
    always_ff @(posedge clk_400) begin
        if (reset) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    assign reset_ap_start_user = reset || !started;

    packet_rx rx0 (
        .clk_400 (clk_400),
        .reset   (reset),
        .pkt_in  (din_leaf_bft2interface),
        .in_word (in_word),
        .in_push (in_push),
        .routes  (routes)
    );

    // ****************************************
    // Stream queues
    // ****************************************
    for (genvar i = 0; i < num_in_ports; i++) begin : g_in_queue
        // A full input queue drops the word, so its ack is left open
        stream_fifo in_q (
            .clk_400 (clk_400),
            .reset   (reset),
            .wr_data (in_word),
            .wr_vld  (in_push[i]),
            .wr_ack  (),
            .rd_data (dout_leaf_interface2user[i]),
            .rd_vld  (vld_interface2user[i]),
            .rd_ack  (ack_user2interface[i])
        );
    end

    for (genvar i = 0; i < num_out_ports; i++) begin : g_out_queue
        stream_fifo out_q (
            .clk_400 (clk_400),
            .reset   (reset),
            .wr_data (din_leaf_user2interface[i]),
            .wr_vld  (vld_user2interface[i]),
            .wr_ack  (ack_interface2user[i]),
            .rd_data (out_word[i]),
            .rd_vld  (out_vld[i]),
            .rd_ack  (out_pop[i])
        );
    end

    packet_tx tx0 (
        .clk_400  (clk_400),
        .reset    (reset),
        .resend   (resend),
        .routes   (routes),
        .out_word (out_word),
        .out_vld  (out_vld),
        .out_pop  (out_pop),
        .pkt_out  (dout_leaf_interface2bft)
    );

endmodule

// File: design/leaf_pkg.sv
package leaf_pkg;

    // ****************************************
    // Field widths of the tree packet
    // ****************************************
    localparam int packet_bits = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits = 5;
    localparam int port_bits = 4;
    localparam int addr_bits = 7;

    // Stream counts on the kernel side
    localparam int num_in_ports = 4;
    localparam int num_out_ports = 6;

    // Every input and output queue has this many entries
    localparam int fifo_depth = 16;

    // ****************************************
    // Types
    // ****************************************
    typedef logic [payload_bits-1:0] word_t;

    // Field order gives valid as the top bit of the 49-bit packet
    typedef struct packed {
        logic                 valid;
        logic [leaf_bits-1:0] dest_leaf;
        logic [port_bits-1:0] dest_port;
        logic [addr_bits-1:0] addr;
        word_t                payload;
    } tree_packet_t;

    // One route table entry, also the low 9 bits of a config payload
    typedef struct packed {
        logic [leaf_bits-1:0] leaf;
        logic [port_bits-1:0] port;
    } route_t;

    // Port 0 is the config port, ports 1 to 4 carry data
    typedef enum logic [1:0] {
        kind_config,
        kind_data,
        kind_none
    } packet_kind_e;

endpackage

// File: design/packet_rx.sv
`timescale 1ns/1ps

module packet_rx (
    input  logic                                clk_400,
    input  logic                                reset,
    input  leaf_pkg::tree_packet_t              pkt_in,
    output leaf_pkg::word_t                     in_word,
    output logic [leaf_pkg::num_in_ports-1:0]   in_push,
    output leaf_pkg::route_t                    routes [leaf_pkg::num_out_ports]
);
    import leaf_pkg::*;

    localparam int route_bits = $bits(route_t);

    packet_kind_e kind;

    // ****************************************
    // Packet classification
    // ****************************************
    always_comb begin
        if (!pkt_in.valid) begin
            kind = kind_none;
        end else if (pkt_in.dest_port == '0) begin
            kind = kind_config;
        end else if (pkt_in.dest_port <= port_bits'(num_in_ports)) begin
            kind = kind_data;
        end else begin
            kind = kind_none;
        end
    end

    // Data words go to the queues in the same cycle they arrive
    assign in_word = pkt_in.payload;

    always_comb begin
        for (int i = 0; i < num_in_ports; i++) begin
            in_push[i] = (kind == kind_data) && (pkt_in.dest_port == port_bits'(i + 1));
        end
    end

    // ****************************************
    // Route table
    // ****************************************
    // Entry j belongs to output stream j+1; addr values outside 1..6 are ignored
    always_ff @(posedge clk_400) begin
        if (reset) begin
            for (int j = 0; j < num_out_ports; j++) begin
                routes[j] <= '0;
            end
        end else if (kind == kind_config) begin
            for (int j = 0; j < num_out_ports; j++) begin
                if (pkt_in.addr == addr_bits'(j + 1)) begin
                    routes[j] <= route_t'(pkt_in.payload[route_bits-1:0]);
                end
            end
        end
    end

endmodule

// File: design/packet_tx.sv
`timescale 1ns/1ps

module packet_tx (
    input  logic                                clk_400,
    input  logic                                reset,
    input  logic                                resend,
    input  leaf_pkg::route_t                    routes [leaf_pkg::num_out_ports],
    input  leaf_pkg::word_t                     out_word [leaf_pkg::num_out_ports],
    input  logic [leaf_pkg::num_out_ports-1:0]  out_vld,
    output logic [leaf_pkg::num_out_ports-1:0]  out_pop,
    output leaf_pkg::tree_packet_t              pkt_out
);
    import leaf_pkg::*;

    localparam int sel_bits = $clog2(num_out_ports);

    logic [sel_bits-1:0] last_grant;
    logic [sel_bits-1:0] pick_idx;
    logic pick_found;
    logic pick_en;
    logic pkt_valid;
    route_t hdr_route;
    logic [addr_bits-1:0] hdr_addr;
    word_t hdr_payload;

    // ****************************************
    // Round-robin pick
    // ****************************************
    // Search starts one past the last grant and wraps over all six queues
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_idx = last_grant;
        for (int off = 1; off <= num_out_ports; off++) begin
            idx = (int'(last_grant) + off) % num_out_ports;
            if (!pick_found && out_vld[idx]) begin
                pick_found = 1'b1;
                pick_idx = sel_bits'(idx);
            end
        end
    end

    assign pick_en = pick_found && !resend;

    always_comb begin
        out_pop = '0;
        if (pick_en) begin
            out_pop[pick_idx] = 1'b1;
        end
    end

    // ****************************************
    // Output packet register
    // ****************************************
    // Under resend a pending packet is held back until resend drops
    always_ff @(posedge clk_400) begin
        if (reset) begin
            pkt_valid <= 1'b0;
            last_grant <= sel_bits'(num_out_ports - 1);
        end else if (!resend) begin
            pkt_valid <= pick_found;
            if (pick_found) begin
                last_grant <= pick_idx;
            end
        end
    end

    // Header comes from the route table at pick time
    always_ff @(posedge clk_400) begin
        if (pick_en) begin
            hdr_route <= routes[pick_idx];
            hdr_addr <= addr_bits'(pick_idx) + 1'b1;
            hdr_payload <= out_word[pick_idx];
        end
    end

    always_comb begin
        pkt_out.valid = pkt_valid && !resend;
        pkt_out.dest_leaf = hdr_route.leaf;
        pkt_out.dest_port = hdr_route.port;
        pkt_out.addr = hdr_addr;
        pkt_out.payload = hdr_payload;
    end

endmodule

// File: design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter int depth = leaf_pkg::fifo_depth
) (
    input  logic            clk_400,
    input  logic            reset,
    input  leaf_pkg::word_t wr_data,
    input  logic            wr_vld,
    output logic            wr_ack,
    output leaf_pkg::word_t rd_data,
    output logic            rd_vld,
    input  logic            rd_ack
);
    import leaf_pkg::*;

    localparam int ptr_bits = $clog2(depth);
    localparam int cnt_bits = $clog2(depth + 1);

    word_t mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;
    logic wr_en;
    logic out_free;
    logic mem_empty;
    logic load_from_mem;
    logic bypass;
    logic mem_write;

    // Ack only looks at stored words, so it never depends on rd_ack
    assign wr_ack = (count != cnt_bits'(depth));
    assign wr_en = wr_vld && wr_ack;
    assign out_free = !rd_vld || rd_ack;
    assign mem_empty = (count == '0);
    assign load_from_mem = out_free && !mem_empty;

    // An empty queue passes the word straight into the output register
    assign bypass = out_free && mem_empty && wr_en;
    assign mem_write = wr_en && !bypass;

    always_ff @(posedge clk_400) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            rd_vld <= 1'b0;
        end else begin
            if (mem_write) begin
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (load_from_mem) begin
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({mem_write, load_from_mem})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            if (out_free) begin
                rd_vld <= !mem_empty || wr_en;
            end
        end
    end

    always_ff @(posedge clk_400) begin
        if (mem_write) begin
            mem[wr_ptr] <= wr_data;
        end
        if (load_from_mem) begin
            rd_data <= mem[rd_ptr];
        end else if (bypass) begin
            rd_data <= wr_data;
        end
    end

endmodule

// File: design/user_kernel.sv
`timescale 1ns/1ps

module user_kernel (
    input  logic                                clk_user,
    input  logic                                reset,
    input  leaf_pkg::word_t                     dout_leaf_interface2user [leaf_pkg::num_in_ports],
    input  logic [leaf_pkg::num_in_ports-1:0]   vld_interface2user,
    output logic [leaf_pkg::num_in_ports-1:0]   ack_user2interface,
    output leaf_pkg::word_t                     din_leaf_user2interface [leaf_pkg::num_out_ports],
    output logic [leaf_pkg::num_out_ports-1:0]  vld_user2interface,
    input  logic [leaf_pkg::num_out_ports-1:0]  ack_interface2user
);
    import leaf_pkg::*;

    logic active;
    logic [num_out_ports-1:0] slot_free;
    logic [num_in_ports-1:0] take;
    logic [num_out_ports-1:0] load;
    word_t total_1;
    word_t total_2;
    word_t sum_1;
    word_t sum_2;

    // ****************************************
    // Input acceptance
    // ****************************************
    // A slot can take a new word if it is empty or being drained this cycle
    assign slot_free = ~vld_user2interface | ack_interface2user;

    // Inputs 1 and 2 also feed the running totals on outputs 5 and 6
    assign ack_user2interface[0] = active && slot_free[0] && slot_free[4];
    assign ack_user2interface[1] = active && slot_free[1] && slot_free[5];
    assign ack_user2interface[2] = active && slot_free[2];
    assign ack_user2interface[3] = active && slot_free[3];

    assign take = vld_interface2user & ack_user2interface;
    assign load = {take[1], take[0], take};

    assign sum_1 = total_1 + dout_leaf_interface2user[0];
    assign sum_2 = total_2 + dout_leaf_interface2user[1];

    // ****************************************
    // Output slots and totals
    // ****************************************
    always_ff @(posedge clk_user) begin
        if (reset) begin
            active <= 1'b0;
            vld_user2interface <= '0;
            total_1 <= '0;
            total_2 <= '0;
        end else begin
            active <= 1'b1;
            for (int j = 0; j < num_out_ports; j++) begin
                if (load[j]) begin
                    vld_user2interface[j] <= 1'b1;
                end else if (ack_interface2user[j]) begin
                    vld_user2interface[j] <= 1'b0;
                end
            end
            if (take[0]) begin
                total_1 <= sum_1;
            end
            if (take[1]) begin
                total_2 <= sum_2;
            end
        end
    end

    always_ff @(posedge clk_user) begin
        for (int i = 0; i < num_in_ports; i++) begin
            if (take[i]) begin
                din_leaf_user2interface[i] <= dout_leaf_interface2user[i] + 1'b1;
            end
        end
        if (take[0]) begin
            din_leaf_user2interface[4] <= sum_1;
        end
        if (take[1]) begin
            din_leaf_user2interface[5] <= sum_2;
        end
    end

endmodule

// File: files.f
+incdir+bench
design/leaf_pkg.sv
design/stream_fifo.sv
design/packet_rx.sv
design/packet_tx.sv
design/leaf_interface.sv
design/user_kernel.sv
design/leaf_i4o6.sv
bench/leaf_tb.sv
